/* Bender.yml */
package:
  name: usb_rx_checker

sources:
  - files:
      - hw/usb_rx_pkg.sv
      - hw/usb_pid_decode.sv
      - hw/usb_crc.sv
      - hw/usb_bit_execute.sv
      - hw/usb_rx_report.sv
      - hw/usb_rx_checker.sv
  - target: test
    files:
      - dv/usb_rx_checker_assertions.sv
      - dv/usb_rx_checker_tb.sv

/* dv/usb_rx_checker_assertions.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module usb_rx_checker_assertions (
    input logic                    clk12,
    input logic                    RST,
    input logic                    in_valid,
    input logic                    in_ready,
    input usb_rx_pkg::usb_byte_t   in_byte,
    input logic                    out_valid,
    input logic                    out_ready,
    input usb_rx_pkg::usb_report_t out_report
);

    // Count of failed assertions
    int fails = 0;

    // An offered byte stays put until in_ready takes it
    in_hold: assert property (@(posedge clk12) disable iff (RST)
        in_valid && !in_ready |=> in_valid && $stable(in_byte))
        else begin
            $error("Input byte changed or was withdrawn before in_ready");
            fails++;
        end

    // A pending report stays put until out_ready takes it
    out_hold: assert property (@(posedge clk12) disable iff (RST)
        out_valid && !out_ready |=> out_valid && $stable(out_report))
        else begin
            $error("Report changed or was withdrawn before out_ready");
            fails++;
        end

    // Reset clears the output and closes the input
    rst_out: assert property (@(posedge clk12) RST |=> !out_valid)
        else begin
            $error("out_valid high during reset");
            fails++;
        end

    rst_in: assert property (@(posedge clk12) RST |=> !in_ready)
        else begin
            $error("in_ready high during reset");
            fails++;
        end

endmodule

bind usb_rx_checker usb_rx_checker_assertions u_assert (
    .clk12      (clk12),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_byte    (in_byte),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_report (out_report)
);

/* dv/usb_rx_checker_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// USB receive checker testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module usb_rx_checker_tb;

    logic                    clk12;
    logic                    RST;
    logic                    in_valid;
    usb_rx_pkg::usb_byte_t   in_byte;
    logic                    in_ready;
    logic                    out_valid;
    usb_rx_pkg::usb_report_t out_report;
    logic                    out_ready;

    // Bytes of the packet under construction and its wire bits before packing
    logic [7:0]              pkt[$];
    logic                    wire_bits[$];
    usb_rx_pkg::usb_byte_t   stim_q[$];
    usb_rx_pkg::usb_report_t exp_q[$];
    int                      n_pkts = 0;
    int                      n_seen = 0;

    usb_rx_checker DUT (
        .clk12      (clk12),
        .RST        (RST),
        .in_valid   (in_valid),
        .in_byte    (in_byte),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_report (out_report),
        .out_ready  (out_ready)
    );

    initial begin
        clk12 = 1'b0;
        forever #4 clk12 = ~clk12;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        assert (got == want) else begin
            fail_run($sformatf("Mismatch at %0t: out_report.%s = 0x%0h, expected 0x%0h",
                               $time, name, got, want));
        end
    endtask

    // One serial step of x^16+x^15+x^2+1 or x^5+x^2+1 with the top bit of the width as feedback
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic w16,
                                             input logic d);
        logic fb;
        fb  = (w16 ? crc[15] : crc[4]) ^ d;
        crc = crc << 1;
        if (fb) begin
            crc = crc ^ (w16 ? 16'h8005 : 16'h0005);
        end
        return w16 ? crc : {11'h0, crc[4:0]};
    endfunction

    // Expected report for one packet whose byte 0 is the PID
    function automatic usb_rx_pkg::usb_report_t usb_expected(input logic [7:0] bytes[$]);
        usb_rx_pkg::usb_report_t r;
        logic [15:0]             crc;
        logic                    w16;
        int                      n;
        n            = bytes.size();
        r            = '0;
        r.pid        = bytes[0][3:0];
        r.byte_count = 8'(n);
        case (bytes[0][3:0])
            usb_rx_pkg::PID_OUT, usb_rx_pkg::PID_IN,
            usb_rx_pkg::PID_SOF, usb_rx_pkg::PID_SETUP:
                r.kind = usb_rx_pkg::KIND_TOKEN;
            usb_rx_pkg::PID_DATA0, usb_rx_pkg::PID_DATA1:
                r.kind = usb_rx_pkg::KIND_DATA;
            usb_rx_pkg::PID_ACK, usb_rx_pkg::PID_NAK, usb_rx_pkg::PID_STALL:
                r.kind = usb_rx_pkg::KIND_HANDSHAKE;
            default:
                r.kind = usb_rx_pkg::KIND_INVALID;
        endcase
        // A PID whose check nibble is wrong is never trusted
        if (bytes[0][7:4] != ~bytes[0][3:0]) begin
            r.kind = usb_rx_pkg::KIND_INVALID;
        end
        r.pid_err = (r.kind == usb_rx_pkg::KIND_INVALID);
        if (r.kind == usb_rx_pkg::KIND_TOKEN || r.kind == usb_rx_pkg::KIND_DATA) begin
            w16 = (r.kind == usb_rx_pkg::KIND_DATA);
            crc = '1;
            for (int i = 1; i < n; i++) begin
                for (int b = 0; b < 8; b++) begin
                    crc = crc_step(crc, w16, bytes[i][b]);
                end
            end
            r.crc_err = w16 ? (crc != usb_rx_pkg::CRC16_RESIDUAL)
                            : (crc[4:0] != usb_rx_pkg::CRC5_RESIDUAL);
        end
        case (r.kind)
            usb_rx_pkg::KIND_TOKEN:     r.len_err = (n != 3);
            usb_rx_pkg::KIND_HANDSHAKE: r.len_err = (n != 1);
            usb_rx_pkg::KIND_DATA:      r.len_err = (n < 3);
            default:                    r.len_err = 1'b0;
        endcase
        // ADDR sits in byte 1, ENDP straddles bytes 1 and 2
        if (r.kind == usb_rx_pkg::KIND_TOKEN && n >= 2) begin
            r.addr    = bytes[1][6:0];
            r.endp[0] = bytes[1][7];
        end
        if (r.kind == usb_rx_pkg::KIND_TOKEN && n >= 3) begin
            r.endp[3:1] = bytes[2][2:0];
        end
        return r;
    endfunction

    // Appends the inverted remainder MSB first, then packs all bits LSB first
    task automatic close_bits(input logic w16);
        logic [15:0] crc;
        logic [7:0]  b;
        crc = '1;
        b   = '0;
        foreach (wire_bits[i]) begin
            crc = crc_step(crc, w16, wire_bits[i]);
        end
        for (int i = (w16 ? 15 : 4); i >= 0; i--) begin
            wire_bits.push_back(~crc[i]);
        end
        foreach (wire_bits[i]) begin
            b[i % 8] = wire_bits[i];
            if (i % 8 == 7) begin
                pkt.push_back(b);
            end
        end
        wire_bits.delete();
    endtask

    task automatic token_packet(input logic [3:0] pid, input logic [6:0] addr,
                                input logic [3:0] endp);
        pkt.delete();
        pkt.push_back({~pid, pid});
        for (int i = 0; i < 7; i++) begin
            wire_bits.push_back(addr[i]);
        end
        for (int i = 0; i < 4; i++) begin
            wire_bits.push_back(endp[i]);
        end
        close_bits(1'b0);
    endtask

    task automatic data_packet(input logic [3:0] pid, input int payload);
        logic [7:0] b;
        pkt.delete();
        pkt.push_back({~pid, pid});
        repeat (payload) begin
            b = 8'($urandom);
            for (int i = 0; i < 8; i++) begin
                wire_bits.push_back(b[i]);
            end
        end
        close_bits(1'b1);
    endtask

    // PID byte as given plus random trailing bytes and no CRC
    task automatic raw_packet(input logic [7:0] pid_b, input int extra);
        pkt.delete();
        pkt.push_back(pid_b);
        repeat (extra) begin
            pkt.push_back(8'($urandom));
        end
    endtask

    task automatic flip_bit();
        int idx;
        int pos;
        idx           = 1 + int'($urandom % (pkt.size() - 1));
        pos           = int'($urandom % 8);
        pkt[idx][pos] = ~pkt[idx][pos];
    endtask

    task automatic queue_packet();
        usb_rx_pkg::usb_byte_t ib;
        exp_q.push_back(usb_expected(pkt));
        foreach (pkt[i]) begin
            ib.data = pkt[i];
            ib.last = (i == pkt.size() - 1);
            stim_q.push_back(ib);
        end
        n_pkts++;
    endtask

    task automatic build_packets();
        logic [3:0] tok_pids [4];
        logic [3:0] hs_pids [3];
        tok_pids = '{usb_rx_pkg::PID_OUT, usb_rx_pkg::PID_IN,
                     usb_rx_pkg::PID_SETUP, usb_rx_pkg::PID_SOF};
        hs_pids  = '{usb_rx_pkg::PID_ACK, usb_rx_pkg::PID_NAK, usb_rx_pkg::PID_STALL};
        // Clean tokens and clean data packets of 3 to 20 bytes
        for (int k = 0; k < 8; k++) begin
            token_packet(tok_pids[k % 4], 7'($urandom), 4'($urandom));
            queue_packet();
        end
        for (int k = 0; k <= 17; k++) begin
            data_packet(k[0] ? usb_rx_pkg::PID_DATA1 : usb_rx_pkg::PID_DATA0, k);
            queue_packet();
        end
        // A single flipped bit after the PID
        for (int k = 0; k < 6; k++) begin
            data_packet(usb_rx_pkg::PID_DATA0, 1 + k * 3);
            flip_bit();
            queue_packet();
            token_packet(tok_pids[k % 4], 7'($urandom), 4'($urandom));
            flip_bit();
            queue_packet();
        end
        // Every code with a broken check nibble and then every code alone
        for (int c = 0; c < 16; c++) begin
            raw_packet({4'(c), 4'(c)}, c % 3);
            queue_packet();
        end
        for (int c = 0; c < 16; c++) begin
            raw_packet({~4'(c), 4'(c)}, 0);
            queue_packet();
        end
        // Length faults
        foreach (hs_pids[k]) begin
            raw_packet({~hs_pids[k], hs_pids[k]}, 1 + k % 2);
            queue_packet();
        end
        token_packet(usb_rx_pkg::PID_IN, 7'h2A, 4'h5);
        void'(pkt.pop_back());
        queue_packet();
        token_packet(usb_rx_pkg::PID_OUT, 7'h11, 4'hA);
        pkt.push_back(8'($urandom));
        queue_packet();
        raw_packet({~usb_rx_pkg::PID_DATA1, usb_rx_pkg::PID_DATA1}, 1);
        queue_packet();
    endtask

    // Byte driver with random gaps between bytes
    initial begin
        void'($urandom(32'h8da6_2726));
        RST      = 1'b1;
        in_valid = 1'b0;
        in_byte  = '0;
        build_packets();
        repeat (2) @(negedge clk12);
        RST = 1'b0;
        foreach (stim_q[i]) begin
            if ($urandom % 4 == 0) begin
                in_valid = 1'b0;
                repeat (1 + $urandom % 3) @(negedge clk12);
            end
            in_valid = 1'b1;
            in_byte  = stim_q[i];
            // in_ready depends on registers only, so it is settled here
            while (!in_ready) begin
                @(negedge clk12);
            end
            @(negedge clk12);
        end
        in_valid = 1'b0;
        wait (n_seen == n_pkts);
        // Room for a stray extra report to show up
        repeat (20) @(negedge clk12);
        $display("STATUS: PASS");
        $finish;
    end

    // A bound handshake assertion that fires ends the run straight away
    initial begin
        wait (DUT.u_assert.fails != 0);
        fail_run("A bound handshake assertion failed during the run");
    end

    // Drives out_ready and checks each report the edge before it is taken
    initial begin
        usb_rx_pkg::usb_report_t want;
        out_ready = 1'b0;
        forever begin
            @(negedge clk12);
            out_ready = ($urandom % 4 != 0);
            if (out_valid && out_ready) begin
                assert (exp_q.size() > 0) else begin
                    fail_run("A report came out with no packet left to match it");
                end
                want = exp_q.pop_front();
                check_field("pid", 16'(out_report.pid), 16'(want.pid));
                check_field("kind", 16'(out_report.kind), 16'(want.kind));
                check_field("pid_err", 16'(out_report.pid_err), 16'(want.pid_err));
                check_field("crc_err", 16'(out_report.crc_err), 16'(want.crc_err));
                check_field("len_err", 16'(out_report.len_err), 16'(want.len_err));
                check_field("byte_count", 16'(out_report.byte_count), 16'(want.byte_count));
                check_field("addr", 16'(out_report.addr), 16'(want.addr));
                check_field("endp", 16'(out_report.endp), 16'(want.endp));
                check_field("spare", 16'(out_report.spare), 16'(want.spare));
                n_seen++;
            end
        end
    end

    // Packets are built before reset ends, so n_pkts is final here
    initial begin
        @(negedge RST);
        repeat (200 * n_pkts) @(posedge clk12);
        fail_run("Timeout waiting for all packet reports to arrive");
    end

endmodule

/* hw/usb_bit_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit serial CRC stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module usb_bit_execute (
    input  logic                  clk12,
    input  logic                  RST,
    input  logic                  beat_valid,
    input  usb_rx_pkg::usb_beat_t beat,
    output logic                  beat_ready,
    output logic                  res_valid,
    output usb_rx_pkg::usb_exec_t res,
    input  logic                  res_ready
);

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_SHIFT,
        EX_OUT
    } ex_state_e;

    ex_state_e             state;
    logic [2:0]            bit_cnt;
    logic [7:0]            sreg;
    usb_rx_pkg::usb_beat_t hold;
    logic                  take;
    logic                  needs_crc;
    logic                  hold_crc;
    logic                  restart;
    logic                  crc_ok;

    assign beat_ready = (state == EX_IDLE);
    assign take       = beat_valid && beat_ready;
    assign res_valid  = (state == EX_OUT);

    // Only tokens and data packets carry a CRC
    assign needs_crc = (beat.kind == usb_rx_pkg::KIND_TOKEN) ||
                       (beat.kind == usb_rx_pkg::KIND_DATA);
    assign hold_crc  = (hold.kind == usb_rx_pkg::KIND_TOKEN) ||
                       (hold.kind == usb_rx_pkg::KIND_DATA);

    // A PID beat reseeds the checker and picks the CRC width
    assign restart = take && beat.first;

    usb_crc u_crc (
        .clk12     (clk12),
        .RST       (RST),
        .restart   (restart),
        .use_crc16 (beat.kind == usb_rx_pkg::KIND_DATA),
        .shift     (state == EX_SHIFT),
        .data      (sreg[0]),
        .crc_ok    (crc_ok)
    );

    always_ff @(posedge clk12) begin
        if (RST) begin
            state   <= EX_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (take) begin
                        bit_cnt <= '0;
                        // PID bytes and CRC-less packets skip the shifter
                        state <= (beat.first || !needs_crc) ? EX_OUT : EX_SHIFT;
                    end
                end
                EX_SHIFT: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= EX_OUT;
                    end
                end
                default: begin
                    if (res_ready) begin
                        state <= EX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB leaves first, matching the wire order
    always_ff @(posedge clk12) begin
        if (take) begin
            hold <= beat;
            sreg <= beat.data;
        end else if (state == EX_SHIFT) begin
            sreg <= {1'b0, sreg[7:1]};
        end
    end

    always_comb begin
        res.beat   = hold;
        res.crc_ok = hold_crc ? crc_ok : 1'b1;
    end

endmodule

/* hw/usb_crc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial USB CRC checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module usb_crc (
    input  logic clk12,
    input  logic RST,
    input  logic restart,
    input  logic use_crc16,
    input  logic shift,
    input  logic data,
    output logic crc_ok
);

    logic [15:0] crc_q;
    logic [15:0] crc_next;
    logic        use16_q;
    logic        fb;

    // Feedback comes from the top bit of whichever width is active
    assign fb = use16_q ? (crc_q[15] ^ data) : (crc_q[4] ^ data);

    // Shift left and XOR in the taps at bits 15, 2 and 0
    // CRC5 shares the low taps so the same update serves both widths
    assign crc_next = {
        crc_q[14] ^ fb,
        crc_q[13:2],
        crc_q[1] ^ fb,
        crc_q[0],
        fb
    };

    always_ff @(posedge clk12) begin
        if (RST || restart) begin
            // Both CRCs start from an all ones remainder
            crc_q   <= '1;
            use16_q <= use_crc16;
        end else if (shift) begin
            crc_q <= crc_next;
        end
    end

    // After the CRC field itself has been shifted in, a clean packet
    // leaves the fixed residual
    assign crc_ok = use16_q ? (crc_q == usb_rx_pkg::CRC16_RESIDUAL)
                            : (crc_q[4:0] == usb_rx_pkg::CRC5_RESIDUAL);

endmodule

/* hw/usb_pid_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PID decode stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module usb_pid_decode (
    input  logic                  clk12,
    input  logic                  RST,
    input  logic                  in_valid,
    input  usb_rx_pkg::usb_byte_t in_byte,
    output logic                  in_ready,
    output logic                  beat_valid,
    output usb_rx_pkg::usb_beat_t beat,
    input  logic                  beat_ready
);

    logic                  running;
    logic                  expect_pid;
    logic                  take;
    usb_rx_pkg::usb_kind_e pid_kind;
    usb_rx_pkg::usb_kind_e pkt_kind;

    // The register takes a byte when empty or when it drains this cycle
    assign in_ready = running && (!beat_valid || beat_ready);
    assign take     = in_valid && in_ready;

    // Classify the byte as if it were a PID
    always_comb begin
        case (in_byte.data[3:0])
            usb_rx_pkg::PID_OUT, usb_rx_pkg::PID_IN,
            usb_rx_pkg::PID_SOF, usb_rx_pkg::PID_SETUP:
                pid_kind = usb_rx_pkg::KIND_TOKEN;
            usb_rx_pkg::PID_DATA0, usb_rx_pkg::PID_DATA1:
                pid_kind = usb_rx_pkg::KIND_DATA;
            usb_rx_pkg::PID_ACK, usb_rx_pkg::PID_NAK, usb_rx_pkg::PID_STALL:
                pid_kind = usb_rx_pkg::KIND_HANDSHAKE;
            default:
                pid_kind = usb_rx_pkg::KIND_INVALID;
        endcase
        // Upper nibble must mirror the code inverted
        if (in_byte.data[7:4] != ~in_byte.data[3:0]) begin
            pid_kind = usb_rx_pkg::KIND_INVALID;
        end
    end

    always_ff @(posedge clk12) begin
        if (RST) begin
            running    <= 1'b0;
            expect_pid <= 1'b1;
            beat_valid <= 1'b0;
            pkt_kind   <= usb_rx_pkg::KIND_INVALID;
        end else begin
            running <= 1'b1;
            if (take) begin
                beat_valid <= 1'b1;
                // The byte after a last byte opens a new packet
                expect_pid <= in_byte.last;
                if (expect_pid) begin
                    pkt_kind <= pid_kind;
                end
            end else if (beat_ready) begin
                beat_valid <= 1'b0;
            end
        end
    end

    // Byte register with its packet tags
    always_ff @(posedge clk12) begin
        if (take) begin
            beat.data  <= in_byte.data;
            beat.first <= expect_pid;
            beat.last  <= in_byte.last;
            beat.kind  <= expect_pid ? pid_kind : pkt_kind;
        end
    end

endmodule

/* hw/usb_rx_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// USB receive packet checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module usb_rx_checker (
    input  logic                    clk12,
    input  logic                    RST,
    input  logic                    in_valid,
    input  usb_rx_pkg::usb_byte_t   in_byte,
    output logic                    in_ready,
    output logic                    out_valid,
    output usb_rx_pkg::usb_report_t out_report,
    input  logic                    out_ready
);

    // Decode to execute
    logic                  beat_valid;
    logic                  beat_ready;
    usb_rx_pkg::usb_beat_t beat;

    // Execute to report
    logic                  res_valid;
    logic                  res_ready;
    usb_rx_pkg::usb_exec_t res;

    usb_pid_decode u_decode (
        .clk12      (clk12),
        .RST        (RST),
        .in_valid   (in_valid),
        .in_byte    (in_byte),
        .in_ready   (in_ready),
        .beat_valid (beat_valid),
        .beat       (beat),
        .beat_ready (beat_ready)
    );

    usb_bit_execute u_execute (
        .clk12      (clk12),
        .RST        (RST),
        .beat_valid (beat_valid),
        .beat       (beat),
        .beat_ready (beat_ready),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready)
    );

    usb_rx_report u_report (
        .clk12      (clk12),
        .RST        (RST),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready),
        .out_valid  (out_valid),
        .out_report (out_report),
        .out_ready  (out_ready)
    );

endmodule

/* hw/usb_rx_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// USB receive checker types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package usb_rx_pkg;

    // PID codes as carried in the low nibble of the PID byte
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SOF   = 4'b0101,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } usb_pid_e;

    // Packet class derived from the PID
    typedef enum logic [1:0] {
        KIND_TOKEN,
        KIND_DATA,
        KIND_HANDSHAKE,
        KIND_INVALID
    } usb_kind_e;

    // One received byte with its end-of-packet flag
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } usb_byte_t;

    // Byte tagged by the decode stage
    typedef struct packed {
        logic [7:0] data;
        logic       first;
        logic       last;
        usb_kind_e  kind;
    } usb_beat_t;

    // Beat leaving execute, crc_ok only counts on the last beat
    typedef struct packed {
        usb_beat_t beat;
        logic      crc_ok;
    } usb_exec_t;

    // Per-packet report, token fields stay zero for other kinds
    typedef struct packed {
        logic [3:0] pid;
        usb_kind_e  kind;
        logic       pid_err;
        logic       crc_err;
        logic       len_err;
        logic [7:0] byte_count;
        logic [6:0] addr;
        logic [3:0] endp;
        logic [3:0] spare;
    } usb_report_t;

    // Remainders left behind by a packet whose CRC is intact
    localparam logic [15:0] CRC16_RESIDUAL = 16'b1000_0000_0000_1101;
    localparam logic [4:0]  CRC5_RESIDUAL  = 5'b0_1100;

    // Byte counts include the PID byte
    localparam logic [7:0] TOKEN_BYTES     = 8'd3;
    localparam logic [7:0] HANDSHAKE_BYTES = 8'd1;
    localparam logic [7:0] DATA_MIN_BYTES  = 8'd3;

endpackage

/* hw/usb_rx_report.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet report stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module usb_rx_report (
    input  logic                    clk12,
    input  logic                    RST,
    input  logic                    res_valid,
    input  usb_rx_pkg::usb_exec_t   res,
    output logic                    res_ready,
    output logic                    out_valid,
    output usb_rx_pkg::usb_report_t out_report,
    input  logic                    out_ready
);

    logic [7:0]            cnt_q;
    logic [7:0]            cnt_next;
    logic [3:0]            pid_q;
    logic [3:0]            pid_cur;
    usb_rx_pkg::usb_kind_e kind_q;
    usb_rx_pkg::usb_kind_e kind_cur;
    logic [6:0]            addr_q;
    logic [6:0]            addr_cur;
    logic [3:0]            endp_q;
    logic [3:0]            endp_cur;
    logic                  len_err;
    logic                  take;

    // A pending report blocks further results
    assign res_ready = !out_valid;
    assign take      = res_valid && res_ready;

    // Packet state as it stands once this beat is counted
    always_comb begin
        if (res.beat.first) begin
            cnt_next = 8'd1;
            pid_cur  = res.beat.data[3:0];
            kind_cur = res.beat.kind;
            addr_cur = '0;
            endp_cur = '0;
        end else begin
            // Saturate rather than wrap on oversized packets
            cnt_next = (cnt_q == 8'hFF) ? cnt_q : cnt_q + 8'd1;
            pid_cur  = pid_q;
            kind_cur = kind_q;
            addr_cur = addr_q;
            endp_cur = endp_q;
        end
        // Token fields are packed ADDR then ENDP, LSB first
        if (kind_cur == usb_rx_pkg::KIND_TOKEN) begin
            if (cnt_next == 8'd2) begin
                addr_cur    = res.beat.data[6:0];
                endp_cur[0] = res.beat.data[7];
            end else if (cnt_next == 8'd3) begin
                endp_cur[3:1] = res.beat.data[2:0];
            end
        end
        case (kind_cur)
            usb_rx_pkg::KIND_TOKEN:     len_err = (cnt_next != usb_rx_pkg::TOKEN_BYTES);
            usb_rx_pkg::KIND_HANDSHAKE: len_err = (cnt_next != usb_rx_pkg::HANDSHAKE_BYTES);
            usb_rx_pkg::KIND_DATA:      len_err = (cnt_next < usb_rx_pkg::DATA_MIN_BYTES);
            default:                    len_err = 1'b0;
        endcase
    end

    always_ff @(posedge clk12) begin
        if (RST) begin
            out_valid <= 1'b0;
            cnt_q     <= '0;
        end else begin
            if (take) begin
                cnt_q <= cnt_next;
            end
            if (take && res.beat.last) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk12) begin
        if (take) begin
            pid_q  <= pid_cur;
            kind_q <= kind_cur;
            addr_q <= addr_cur;
            endp_q <= endp_cur;
        end
        if (take && res.beat.last) begin
            out_report <= '{
                pid:        pid_cur,
                kind:       kind_cur,
                pid_err:    (kind_cur == usb_rx_pkg::KIND_INVALID),
                crc_err:    !res.crc_ok,
                len_err:    len_err,
                byte_count: cnt_next,
                addr:       addr_cur,
                endp:       endp_cur,
                spare:      4'h0
            };
        end
    end

endmodule

/* usb_rx_checker.f */
hw/usb_rx_pkg.sv
hw/usb_pid_decode.sv
hw/usb_crc.sv
hw/usb_bit_execute.sv
hw/usb_rx_report.sv
hw/usb_rx_checker.sv
dv/usb_rx_checker_assertions.sv
dv/usb_rx_checker_tb.sv
